//--- files.f
src/csr_pkg.sv
src/csr_decode.sv
src/csr_slot.sv
src/csr_read_mux.sv
src/csr_unit.sv
tests/csr_unit_assert.sv
tests/tb_csr_unit.sv

//--- run.sh
#!/bin/sh
# build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_csr_unit \
    -f files.f \
    -o tb_csr_unit_sim

out=$(./obj_dir/tb_csr_unit_sim)
echo "$out"

if echo "$out" | grep -qF -- '** PASS **'; then
    exit 0
fi
echo "simulation did not pass"
exit 1

//--- tests/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
();

    // expected outputs plus the shadow state after the edge
    typedef struct packed {
        logic [31:0]      rdata;
        logic             illegal;
        logic             trap;
        logic             mret;
        logic [3:0][31:0] next;
    } model_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] wr_data;
    logic        stall_n;
    logic [31:0] rdata;
    logic        illegal;
    logic        trap;
    logic        mret;
    logic [31:0] mtvec;
    logic [31:0] mepc;

    // shadow CSRs in slot order: mstatus, mtvec, mepc, mcause
    logic [3:0][31:0] shadow;
    logic [31:0]      rng = 32'd71;
    logic [11:0]      addr_pool [5] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, 12'h7C0};

    string       cur_name = "idle";
    logic [31:0] exp_rdata = '0;
    logic        exp_illegal = 1'b0;
    logic        exp_trap = 1'b0;
    logic        exp_mret = 1'b0;
    logic [31:0] exp_mtvec = '0;
    logic [31:0] exp_mepc = '0;
    int          issue_seq = 0;
    int          done_seq = 0;
    int          chk_cnt = 0;
    int          err_cnt = 0;
    logic        abort = 1'b0;

    csr_unit #(
        .XLEN_P (XLEN)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_i   (instr),
        .pc_i      (pc),
        .wr_data_i (wr_data),
        .stall_n_i (stall_n),
        .rdata_o   (rdata),
        .illegal_o (illegal),
        .trap_o    (trap),
        .mret_o    (mret),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] a,
                                              input logic [4:0] rs1, input logic [4:0] rd);
        return {a, rs1, f3, rd, 7'b1110011};
    endfunction

    // one cycle of the CSR rules applied to the shadow state
    function automatic model_t model_step(input logic [31:0] ins, input logic [31:0] pc_v,
                                          input logic [31:0] wd, input logic run,
                                          input logic [3:0][31:0] st);
        model_t      res;
        logic [2:0]  f3;
        logic [11:0] csr_addr;
        logic        is_csr;
        logic        known;
        logic [1:0]  idx;
        logic [31:0] mask;
        logic [31:0] old_v;
        logic [31:0] new_v;

        res.rdata   = '0;
        res.illegal = 1'b0;
        res.trap    = 1'b0;
        res.mret    = 1'b0;
        res.next    = st;
        f3          = ins[14:12];
        csr_addr    = ins[31:20];
        is_csr      = run && (ins[6:0] == 7'b1110011) && (f3 != 3'd0) && (f3 <= 3'd3);
        known       = 1'b1;
        idx         = 2'd0;
        mask        = 32'h0000_0088;
        old_v       = '0;
        new_v       = '0;
        case (csr_addr)
            12'h300: begin
                idx  = 2'd0;
                mask = 32'h0000_0088;
            end
            12'h305: begin
                idx  = 2'd1;
                mask = 32'hFFFF_FFFC;
            end
            12'h341: begin
                idx  = 2'd2;
                mask = 32'hFFFF_FFFC;
            end
            12'h342: begin
                idx  = 2'd3;
                mask = 32'hFFFF_FFFF;
            end
            default: known = 1'b0;
        endcase
        if (is_csr) begin
            if (known) begin
                old_v = st[idx];
                case (f3)
                    3'd1:    new_v = wd;
                    3'd2:    new_v = old_v | wd;
                    default: new_v = old_v & ~wd;
                endcase
                res.rdata     = old_v;
                res.next[idx] = (old_v & ~mask) | (new_v & mask);
            end else begin
                res.illegal = 1'b1;
            end
        end
        if (run && ins == 32'h0000_0073) begin
            res.trap        = 1'b1;
            res.next[2'd2]  = pc_v & 32'hFFFF_FFFC;
            res.next[2'd3]  = 32'd11;
            res.next[2'd0][7] = st[2'd0][3];
            res.next[2'd0][3] = 1'b0;
        end
        if (run && ins == 32'h3020_0073) begin
            res.mret          = 1'b1;
            res.next[2'd0][3] = st[2'd0][7];
            res.next[2'd0][7] = 1'b1;
        end
        return res;
    endfunction

    task automatic check_word(input string field, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        chk_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("FAIL %s %s: expected %h, actual %h", cur_name, field, exp_v, act_v);
        end
    endtask

    task automatic check_bit(input string field, input logic exp_v, input logic act_v);
        chk_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("FAIL %s %s: expected %b, actual %b", cur_name, field, exp_v, act_v);
        end
    endtask

    // compare a quarter period after the inputs change
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (done_seq != issue_seq) begin
                check_word("rdata", exp_rdata, rdata);
                check_bit("illegal", exp_illegal, illegal);
                check_bit("trap", exp_trap, trap);
                check_bit("mret", exp_mret, mret);
                check_word("mtvec", exp_mtvec, mtvec);
                check_word("mepc", exp_mepc, mepc);
                done_seq = issue_seq;
            end
        end
    end

    task automatic issue(input string name, input logic [31:0] ins, input logic [31:0] pc_v,
                         input logic [31:0] wd, input logic run);
        model_t res;
        int     ticks;

        if (abort) begin
            return;
        end
        @(negedge clk);
        instr   = ins;
        pc      = pc_v;
        wr_data = wd;
        stall_n = run;
        res         = model_step(ins, pc_v, wd, run, shadow);
        cur_name    = name;
        exp_rdata   = res.rdata;
        exp_illegal = res.illegal;
        exp_trap    = res.trap;
        exp_mret    = res.mret;
        // registered outputs still show the state before this edge
        exp_mtvec   = shadow[2'd1];
        exp_mepc    = shadow[2'd2];
        shadow      = res.next;
        issue_seq++;
        ticks = 0;
        while (done_seq != issue_seq && !abort) begin
            #1;
            ticks++;
            if (ticks > 8) begin
                $display("timeout: comparator never checked step %0d (%s)", issue_seq, name);
                err_cnt++;
                abort = 1'b1;
            end
        end
    endtask

    task automatic read_csr(input string name, input logic [11:0] a);
        issue(name, csr_instr(F3_CSRRS, a, 5'd0, 5'd7), 32'h0, 32'h0, 1'b1);
    endtask

    task automatic read_all(input string name);
        read_csr(name, CSR_MSTATUS);
        read_csr(name, CSR_MTVEC);
        read_csr(name, CSR_MEPC);
        read_csr(name, CSR_MCAUSE);
    endtask

    task automatic random_mix(input int count);
        logic [2:0]  sel;
        logic [2:0]  pick;
        logic        run;
        logic [31:0] wd;
        logic [31:0] pc_v;
        logic [31:0] ins;
        logic [31:0] fields;

        for (int n = 0; n < count; n++) begin
            rng    = lcg_next(rng);
            sel    = rng[30:28];
            pick   = rng[27:25];
            run    = (rng[24:22] != 3'd0);
            fields = rng;
            if (pick > 3'd4) begin
                pick = pick - 3'd4;
            end
            rng  = lcg_next(rng);
            wd   = rng;
            rng  = lcg_next(rng);
            pc_v = rng;
            case (sel)
                3'd0, 3'd1: ins = csr_instr(F3_CSRRW, addr_pool[pick], fields[19:15], fields[11:7]);
                3'd2:       ins = csr_instr(F3_CSRRS, addr_pool[pick], fields[19:15], fields[11:7]);
                3'd3:       ins = csr_instr(F3_CSRRC, addr_pool[pick], fields[19:15], fields[11:7]);
                3'd4:       ins = 32'h0000_0073;
                3'd5:       ins = 32'h3020_0073;
                // arbitrary SYSTEM word, mostly unsupported forms
                3'd6:       ins = {pc_v[31:7], 7'b1110011};
                default:    ins = 32'h0000_0013;
            endcase
            issue("random", ins, pc_v, wd, run);
        end
    endtask

    initial begin
        int ticks;

        rst_n   = 1'b0;
        instr   = 32'h0000_0013;
        pc      = 32'h0;
        wr_data = 32'h0;
        stall_n = 1'b0;
        shadow  = {32'h0, 32'h0, 32'h0, 32'h0000_1800};
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        ticks = 0;
        while ((trap !== 1'b0 || mret !== 1'b0 || illegal !== 1'b0) && !abort) begin
            @(negedge clk);
            ticks++;
            if (ticks > 4) begin
                $display("timeout: control outputs stayed active after reset");
                err_cnt++;
                abort = 1'b1;
            end
        end

        read_all("reset");

        issue("rmw", csr_instr(F3_CSRRW, CSR_MTVEC, 5'd1, 5'd2), 32'h0, 32'h8000_0103, 1'b1);
        read_csr("rmw", CSR_MTVEC);
        issue("rmw", csr_instr(F3_CSRRS, CSR_MTVEC, 5'd1, 5'd2), 32'h0, 32'h0000_0F00, 1'b1);
        issue("rmw", csr_instr(F3_CSRRC, CSR_MTVEC, 5'd1, 5'd2), 32'h0, 32'h8000_0000, 1'b1);
        read_csr("rmw", CSR_MTVEC);
        // only MIE and MPIE take the ones
        issue("rmw", csr_instr(F3_CSRRW, CSR_MSTATUS, 5'd3, 5'd4), 32'h0, 32'hFFFF_FFFF, 1'b1);
        read_csr("rmw", CSR_MSTATUS);
        issue("rmw", csr_instr(F3_CSRRC, CSR_MSTATUS, 5'd3, 5'd4), 32'h0, 32'h0000_0008, 1'b1);
        read_csr("rmw", CSR_MSTATUS);
        issue("rmw", csr_instr(F3_CSRRW, CSR_MEPC, 5'd5, 5'd6), 32'h0, 32'h1234_5677, 1'b1);
        issue("rmw", csr_instr(F3_CSRRS, CSR_MCAUSE, 5'd5, 5'd6), 32'h0, 32'h0000_00F0, 1'b1);
        issue("rmw", csr_instr(F3_CSRRC, CSR_MCAUSE, 5'd5, 5'd6), 32'h0, 32'h0000_0030, 1'b1);
        read_all("rmw");

        issue("illegal", csr_instr(F3_CSRRW, 12'h7C0, 5'd1, 5'd1), 32'h0, 32'hDEAD_BEEF, 1'b1);
        issue("illegal", csr_instr(F3_CSRRS, 12'h301, 5'd1, 5'd1), 32'h0, 32'hFFFF_FFFF, 1'b1);
        issue("illegal", csr_instr(F3_CSRRC, 12'h344, 5'd1, 5'd1), 32'h0, 32'hFFFF_FFFF, 1'b1);
        read_all("illegal");

        issue("ecall", csr_instr(F3_CSRRW, CSR_MTVEC, 5'd1, 5'd0), 32'h0, 32'h0000_0100, 1'b1);
        // MIE set and MPIE clear, so the swap is visible
        issue("ecall", csr_instr(F3_CSRRW, CSR_MSTATUS, 5'd1, 5'd0), 32'h0, 32'h0000_0008, 1'b1);
        issue("ecall", 32'h0000_0073, 32'h2000_0047, 32'h0, 1'b1);
        read_all("ecall");

        issue("mret", 32'h3020_0073, 32'h0, 32'h0, 1'b1);
        read_all("mret");
        // MPIE clear, so MIE drops and MPIE comes back set
        issue("mret", csr_instr(F3_CSRRC, CSR_MSTATUS, 5'd1, 5'd0), 32'h0, 32'h0000_0080, 1'b1);
        issue("mret", 32'h3020_0073, 32'h0, 32'h0, 1'b1);
        read_csr("mret", CSR_MSTATUS);

        // frozen unit ignores everything
        issue("stall", csr_instr(F3_CSRRW, CSR_MTVEC, 5'd1, 5'd1), 32'h0, 32'hFFFF_FFFF, 1'b0);
        issue("stall", 32'h0000_0073, 32'h4000_0000, 32'h0, 1'b0);
        issue("stall", 32'h3020_0073, 32'h0, 32'h0, 1'b0);
        issue("stall", csr_instr(F3_CSRRW, 12'h7C0, 5'd1, 5'd1), 32'h0, 32'h1, 1'b0);
        read_all("stall");

        random_mix(400);
        read_all("final");

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0 && !abort) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/csr_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assert
    import csr_pkg::*;
(
    input wire logic                         clk,
    input wire logic                         rst_n,
    input wire logic                         stall_n_i,
    input wire logic                         trap_i,
    input wire logic                         mret_i,
    input wire logic [XLEN-1:0]              mtvec_i,
    input wire logic [XLEN-1:0]              mepc_i,
    input wire logic [NUM_CSR-1:0][XLEN-1:0] value_i
);

    // one instruction cannot be both
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_i && mret_i))
        else $error("trap and mret active in the same cycle");

    // no slot may move across a stalled edge
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !stall_n_i |=> $stable(value_i))
        else $error("CSR changed across a stalled cycle");

    a_mtvec_align: assert property (@(posedge clk) disable iff (!rst_n)
        mtvec_i[1:0] == 2'b00)
        else $error("mtvec not word aligned");

    a_mepc_align: assert property (@(posedge clk) disable iff (!rst_n)
        mepc_i[1:0] == 2'b00)
        else $error("mepc not word aligned");

endmodule

bind csr_unit csr_unit_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_n_i (stall_n_i),
    .trap_i    (trap_o),
    .mret_i    (mret_o),
    .mtvec_i   (mtvec_o),
    .mepc_i    (mepc_o),
    .value_i   (value)
);

`default_nettype wire

//--- src/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter int XLEN_P = XLEN
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [XLEN_P-1:0] instr_i,
    input  wire logic [XLEN_P-1:0] pc_i,
    input  wire logic [XLEN_P-1:0] wr_data_i,
    input  wire logic              stall_n_i,
    output logic      [XLEN_P-1:0] rdata_o,
    output logic                   illegal_o,
    output logic                   trap_o,
    output logic                   mret_o,
    output logic      [XLEN_P-1:0] mtvec_o,
    output logic      [XLEN_P-1:0] mepc_o
);

    csr_cmd_t                       cmd;
    csr_evt_t                       evt;
    logic [NUM_CSR-1:0]             hit;
    logic [NUM_CSR-1:0][XLEN_P-1:0] value;

    // the command structs are sized by the package width
    if (XLEN_P != XLEN) begin : g_width_check
        $error("csr_unit: XLEN_P must equal csr_pkg::XLEN");
    end

    csr_decode u_decode (
        .instr_i   (instr_i),
        .pc_i      (pc_i),
        .wr_data_i (wr_data_i),
        .stall_n_i (stall_n_i),
        .cmd_o     (cmd),
        .evt_o     (evt)
    );

    // one register slot per implemented CSR
    for (genvar i = 0; i < NUM_CSR; i++) begin : g_slot
        csr_slot #(
            .ADDR      (SLOT_ADDR[i]),
            .RESET_VAL (SLOT_RESET[i]),
            .WMASK     (SLOT_WMASK[i]),
            .TRAP_KIND (SLOT_KIND[i])
        ) u_slot (
            .clk     (clk),
            .rst_n   (rst_n),
            .cmd_i   (cmd),
            .evt_i   (evt),
            .hit_o   (hit[i]),
            .value_o (value[i])
        );
    end

    csr_read_mux #(
        .N (NUM_CSR)
    ) u_mux (
        .hit_i     (hit),
        .value_i   (value),
        .op_i      (cmd.op),
        .rdata_o   (rdata_o),
        .illegal_o (illegal_o)
    );

    // redirect info for the fetch stage
    assign trap_o  = evt.ecall;
    assign mret_o  = evt.mret;
    assign mtvec_o = value[IDX_MTVEC];
    assign mepc_o  = value[IDX_MEPC];

endmodule

`default_nettype wire

//--- src/csr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux
    import csr_pkg::*;
#(
    parameter int N = NUM_CSR
) (
    input  wire logic [N-1:0]           hit_i,
    input  wire logic [N-1:0][XLEN-1:0] value_i,
    input  wire csr_op_e                op_i,
    output logic [XLEN-1:0]             rdata_o,
    output logic                        illegal_o
);

    logic any_hit;

    assign any_hit = |hit_i;

    // gated OR, stays at zero when nothing is addressed
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < N; i++) begin
            rdata_o = rdata_o | (value_i[i] & {XLEN{hit_i[i]}});
        end
    end

    // a real access that named no implemented CSR
    assign illegal_o = (op_i != OP_NONE) && !any_hit;

endmodule

`default_nettype wire

//--- src/csr_slot.sv
`timescale 1ns/1ps
`default_nettype none

module csr_slot
    import csr_pkg::*;
#(
    parameter logic [11:0]     ADDR      = 12'h000,
    parameter logic [XLEN-1:0] RESET_VAL = '0,
    parameter logic [XLEN-1:0] WMASK     = '1,
    parameter trap_kind_e      TRAP_KIND = TK_NONE
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire csr_cmd_t        cmd_i,
    input  wire csr_evt_t        evt_i,
    output logic                 hit_o,
    output logic [XLEN-1:0]      value_o
);

    logic [XLEN-1:0] value_q;
    logic [XLEN-1:0] op_val;
    logic [XLEN-1:0] wr_val;
    logic            trap_en;
    logic [XLEN-1:0] trap_val;

    // address match is local to the slot
    assign hit_o   = (cmd_i.op != OP_NONE) && (cmd_i.addr == ADDR);
    assign value_o = value_q;

    // read-modify-write against our own old value
    always_comb begin
        case (cmd_i.op)
            OP_RW:   op_val = cmd_i.wdata;
            OP_RS:   op_val = value_q | cmd_i.wdata;
            OP_RC:   op_val = value_q & ~cmd_i.wdata;
            default: op_val = value_q;
        endcase
    end

    // read-only bits hold
    assign wr_val = (value_q & ~WMASK) | (op_val & WMASK);

    // event update, chosen per slot kind
    always_comb begin
        trap_en  = 1'b0;
        trap_val = value_q;
        case (TRAP_KIND)
            TK_EPC: begin
                trap_en  = evt_i.ecall;
                trap_val = (value_q & ~WMASK) | (evt_i.pc & WMASK);
            end
            TK_CAUSE: begin
                trap_en  = evt_i.ecall;
                trap_val = CAUSE_ECALL_M;
            end
            TK_STATUS: begin
                trap_en = evt_i.ecall | evt_i.mret;
                if (evt_i.ecall) begin
                    // stash MIE, then mask interrupts
                    trap_val[MSTATUS_MPIE_BIT] = value_q[MSTATUS_MIE_BIT];
                    trap_val[MSTATUS_MIE_BIT]  = 1'b0;
                end else begin
                    trap_val[MSTATUS_MIE_BIT]  = value_q[MSTATUS_MPIE_BIT];
                    trap_val[MSTATUS_MPIE_BIT] = 1'b1;
                end
            end
            default: begin
                trap_en  = 1'b0;
                trap_val = value_q;
            end
        endcase
    end

    // events win over a CSR write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_q <= RESET_VAL;
        end else if (trap_en) begin
            value_q <= trap_val;
        end else if (hit_o) begin
            value_q <= wr_val;
        end
    end

endmodule

`default_nettype wire

//--- src/csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  wire logic [XLEN-1:0] instr_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] wr_data_i,
    input  wire logic            stall_n_i,
    output csr_cmd_t             cmd_o,
    output csr_evt_t             evt_o
);

    // instruction fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [4:0]  rd;

    logic        is_system;
    logic        is_priv;
    logic        regs_zero;
    csr_op_e     op_raw;

    assign opcode  = instr_i[6:0];
    assign rd      = instr_i[11:7];
    assign funct3  = instr_i[14:12];
    assign rs1     = instr_i[19:15];
    // CSR address and funct12 share the top field
    assign funct12 = instr_i[31:20];

    assign is_system = (opcode == OPC_SYSTEM);
    assign is_priv   = is_system && (funct3 == F3_PRIV);
    assign regs_zero = (rs1 == 5'd0) && (rd == 5'd0);

    // funct3 to operation, register forms only
    always_comb begin
        case (funct3)
            F3_CSRRW: op_raw = OP_RW;
            F3_CSRRS: op_raw = OP_RS;
            F3_CSRRC: op_raw = OP_RC;
            default:  op_raw = OP_NONE;
        endcase
    end

    // a frozen pipeline issues nothing
    always_comb begin
        cmd_o.addr  = funct12;
        cmd_o.wdata = wr_data_i;
        if (is_system && stall_n_i) begin
            cmd_o.op = op_raw;
        end else begin
            cmd_o.op = OP_NONE;
        end
    end

    // ecall and mret only on their exact encodings
    always_comb begin
        evt_o.pc    = pc_i;
        evt_o.ecall = stall_n_i && is_priv && regs_zero && (funct12 == F12_ECALL);
        evt_o.mret  = stall_n_i && is_priv && regs_zero && (funct12 == F12_MRET);
    end

endmodule

`default_nettype wire

//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // datapath width and number of implemented CSRs
    localparam int XLEN    = 32;
    localparam int NUM_CSR = 4;

    // machine-mode CSR addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // instruction fields of the SYSTEM major opcode
    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    localparam logic [2:0]  F3_PRIV    = 3'd0;
    localparam logic [2:0]  F3_CSRRW   = 3'd1;
    localparam logic [2:0]  F3_CSRRS   = 3'd2;
    localparam logic [2:0]  F3_CSRRC   = 3'd3;
    // funct12 of the privileged returns and calls
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // mstatus bits that this core models
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;
    // MPP fixed at machine mode
    localparam logic [XLEN-1:0] MSTATUS_RESET = 32'h0000_1800;
    localparam logic [XLEN-1:0] MSTATUS_WMASK =
        (32'd1 << MSTATUS_MIE_BIT) | (32'd1 << MSTATUS_MPIE_BIT);
    // word aligned registers, low two bits stay zero
    localparam logic [XLEN-1:0] ALIGN_WMASK   = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] FULL_WMASK    = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_RW,
        OP_RS,
        OP_RC
    } csr_op_e;

    // how a slot reacts to ecall / mret
    typedef enum logic [1:0] {
        TK_NONE,
        TK_STATUS,
        TK_EPC,
        TK_CAUSE
    } trap_kind_e;

    typedef struct packed {
        csr_op_e           op;
        logic [11:0]       addr;
        logic [XLEN-1:0]   wdata;
    } csr_cmd_t;

    typedef struct packed {
        logic              ecall;
        logic              mret;
        logic [XLEN-1:0]   pc;
    } csr_evt_t;

    // slot indices into the tables below
    localparam int IDX_MSTATUS = 0;
    localparam int IDX_MTVEC   = 1;
    localparam int IDX_MEPC    = 2;
    localparam int IDX_MCAUSE  = 3;

    // per-slot configuration, ordered by slot index
    localparam logic [11:0] SLOT_ADDR [NUM_CSR] =
        '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
    localparam logic [XLEN-1:0] SLOT_RESET [NUM_CSR] =
        '{MSTATUS_RESET, 32'd0, 32'd0, 32'd0};
    localparam logic [XLEN-1:0] SLOT_WMASK [NUM_CSR] =
        '{MSTATUS_WMASK, ALIGN_WMASK, ALIGN_WMASK, FULL_WMASK};
    localparam trap_kind_e SLOT_KIND [NUM_CSR] =
        '{TK_STATUS, TK_NONE, TK_EPC, TK_CAUSE};

endpackage

`default_nettype wire
